/* source/text_pkg.sv */
package text_pkg;

  // 7-bit ascii, matches the font rom address width
  typedef logic [6:0] char_code_t;

  // label occupies the first 16 text columns of a row
  localparam int LABEL_LEN = 16;
  // two score digits start right after the label
  localparam int SCORE_COL = 16;

  // pixel size of one text cell
  localparam int CELL_W = 8;
  localparam int CELL_H = 16;

  // punctuation and digits
  localparam char_code_t CODE_BLANK = 7'h20;
  localparam char_code_t CODE_COLON = 7'h3a;
  localparam char_code_t CODE_ZERO  = 7'h30;

  // upper case letters used by the labels
  localparam char_code_t CODE_CAP_B = 7'h42;
  localparam char_code_t CODE_CAP_D = 7'h44;
  localparam char_code_t CODE_CAP_E = 7'h45;
  localparam char_code_t CODE_CAP_L = 7'h4c;
  localparam char_code_t CODE_CAP_P = 7'h50;
  localparam char_code_t CODE_CAP_R = 7'h52;
  localparam char_code_t CODE_CAP_U = 7'h55;

  // lower case letters of "layer"
  localparam char_code_t CODE_A = 7'h61;
  localparam char_code_t CODE_E = 7'h65;
  localparam char_code_t CODE_L = 7'h6c;
  localparam char_code_t CODE_R = 7'h72;
  localparam char_code_t CODE_Y = 7'h79;

  // which label table a rom instance holds
  typedef enum logic {
    PLAYER_BLUE,
    PLAYER_RED
  } player_e;

endpackage

/* source/video_pkg.sv */
package video_pkg;

  // pixel coordinate, wide enough for any common raster total
  typedef logic [11:0] coord_t;

  // row inside a 16-line cell
  typedef logic [3:0] glyph_row_t;

  // column inside an 8-pixel cell
  typedef logic [2:0] glyph_col_t;

  // index into the 16-character label string
  typedef logic [3:0] label_idx_t;

endpackage

/* source/video_timing.sv */
module video_timing import video_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic   clk,
  input  logic   rst_n,
  output coord_t x,
  output coord_t y,
  output logic   hsync_raw,
  output logic   vsync_raw,
  output logic   active_raw
);

  // full frame size including blanking
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // sync pulse window, starts after active plus front porch
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  coord_t h_next;
  coord_t v_next;

  // next counter values, line advances on horizontal wrap
  always_comb begin
    h_next = h_cnt + 1'b1;
    v_next = v_cnt;
    if (h_cnt == coord_t'(H_TOTAL - 1)) begin
      h_next = '0;
      if (v_cnt == coord_t'(V_TOTAL - 1)) begin
        v_next = '0;
      end else begin
        v_next = v_cnt + 1'b1;
      end
    end
  end

  // flags are decoded from the next count so they line up with x and y
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt      <= '0;
      v_cnt      <= '0;
      hsync_raw  <= 1'b1;
      vsync_raw  <= 1'b1;
      active_raw <= 1'b0;
    end else begin
      h_cnt      <= h_next;
      v_cnt      <= v_next;
      // active low sync pulses
      hsync_raw  <= !((h_next >= coord_t'(H_SYNC_START)) && (h_next < coord_t'(H_SYNC_END)));
      vsync_raw  <= !((v_next >= coord_t'(V_SYNC_START)) && (v_next < coord_t'(V_SYNC_END)));
      active_raw <= (h_next < coord_t'(H_ACTIVE)) && (v_next < coord_t'(V_ACTIVE));
    end
  end

  assign x = h_cnt;
  assign y = v_cnt;

endmodule

/* source/label_rom.sv */
module label_rom import text_pkg::*, video_pkg::*; #(
  parameter player_e PLAYER = PLAYER_BLUE
) (
  input  label_idx_t cell_idx,
  output char_code_t char_code
);

  // "BLUE   Player  :" or "RED    Player  :"
  // cells 7 to 15 are shared, only the name part differs
  always_comb begin
    char_code = CODE_BLANK;
    case (cell_idx)
      4'd0: char_code = (PLAYER == PLAYER_BLUE) ? CODE_CAP_B : CODE_CAP_R;
      4'd1: char_code = (PLAYER == PLAYER_BLUE) ? CODE_CAP_L : CODE_CAP_E;
      4'd2: char_code = (PLAYER == PLAYER_BLUE) ? CODE_CAP_U : CODE_CAP_D;
      4'd3: char_code = (PLAYER == PLAYER_BLUE) ? CODE_CAP_E : CODE_BLANK;
      // padding before the word Player
      4'd4: char_code = CODE_BLANK;
      4'd5: char_code = CODE_BLANK;
      4'd6: char_code = CODE_BLANK;
      4'd7: char_code = CODE_CAP_P;
      4'd8: char_code = CODE_L;
      4'd9: char_code = CODE_A;
      4'd10: char_code = CODE_Y;
      4'd11: char_code = CODE_E;
      4'd12: char_code = CODE_R;
      // gap then colon ahead of the score digits
      4'd13: char_code = CODE_BLANK;
      4'd14: char_code = CODE_BLANK;
      4'd15: char_code = CODE_COLON;
      default: char_code = CODE_BLANK;
    endcase
  end

endmodule

/* source/score_digits.sv */
module score_digits import text_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       blue_inc,
  input  logic       red_inc,
  input  logic       score_clear,
  output char_code_t blue_tens,
  output char_code_t blue_ones,
  output char_code_t red_tens,
  output char_code_t red_ones
);

  // bcd digits, tens in the upper nibble
  logic [7:0] blue_bcd;
  logic [7:0] red_bcd;

  // two-digit bcd increment, 99 rolls over to 00
  function automatic logic [7:0] bcd_inc(input logic [7:0] val);
    logic [3:0] tens;
    logic [3:0] ones;
    tens = val[7:4];
    ones = val[3:0];
    if (ones == 4'd9) begin
      ones = 4'd0;
      // carry into tens
      if (tens == 4'd9) begin
        tens = 4'd0;
      end else begin
        tens = tens + 4'd1;
      end
    end else begin
      ones = ones + 4'd1;
    end
    return {tens, ones};
  endfunction

  // clear takes priority over either increment
  always_ff @(posedge clk) begin
    if (!rst_n || score_clear) begin
      blue_bcd <= 8'h00;
      red_bcd  <= 8'h00;
    end else begin
      if (blue_inc) begin
        blue_bcd <= bcd_inc(blue_bcd);
      end
      if (red_inc) begin
        red_bcd <= bcd_inc(red_bcd);
      end
    end
  end

  // ascii digit is '0' plus the digit value
  assign blue_tens = CODE_ZERO + {3'b000, blue_bcd[7:4]};
  assign blue_ones = CODE_ZERO + {3'b000, blue_bcd[3:0]};
  assign red_tens  = CODE_ZERO + {3'b000, red_bcd[7:4]};
  assign red_ones  = CODE_ZERO + {3'b000, red_bcd[3:0]};

endmodule

/* source/text_layer.sv */
module text_layer import text_pkg::*, video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  coord_t     x,
  input  coord_t     y,
  input  logic       hsync_raw,
  input  logic       vsync_raw,
  input  logic       active_raw,
  output label_idx_t cell_idx,
  input  char_code_t blue_label,
  input  char_code_t red_label,
  input  char_code_t blue_tens,
  input  char_code_t blue_ones,
  input  char_code_t red_tens,
  input  char_code_t red_ones,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output char_code_t char_code,
  output glyph_row_t glyph_row,
  output glyph_col_t glyph_col
);

  // cell sizes are powers of two, so split by bit slicing
  localparam int COL_BITS = $clog2(CELL_W);
  localparam int ROW_BITS = $clog2(CELL_H);

  coord_t     text_col;
  coord_t     text_row;
  char_code_t sel_code;

  assign text_col = x >> COL_BITS;
  assign text_row = y >> ROW_BITS;

  // both label roms are addressed with the same column
  assign cell_idx = text_col[$bits(label_idx_t)-1:0];

  // character select, blank outside active video
  always_comb begin
    sel_code = CODE_BLANK;
    if (active_raw) begin
      if (text_col < coord_t'(LABEL_LEN)) begin
        if (text_row == coord_t'(0)) begin
          sel_code = blue_label;
        end else if (text_row == coord_t'(1)) begin
          sel_code = red_label;
        end
      end else if (text_col == coord_t'(SCORE_COL)) begin
        // tens digit
        if (text_row == coord_t'(0)) begin
          sel_code = blue_tens;
        end else if (text_row == coord_t'(1)) begin
          sel_code = red_tens;
        end
      end else if (text_col == coord_t'(SCORE_COL + 1)) begin
        // ones digit
        if (text_row == coord_t'(0)) begin
          sel_code = blue_ones;
        end else if (text_row == coord_t'(1)) begin
          sel_code = red_ones;
        end
      end
    end
  end

  // control and character, sync idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync     <= 1'b1;
      vsync     <= 1'b1;
      active    <= 1'b0;
      char_code <= CODE_BLANK;
    end else begin
      hsync     <= hsync_raw;
      vsync     <= vsync_raw;
      active    <= active_raw;
      char_code <= sel_code;
    end
  end

  // glyph position inside the cell, same stage as char_code
  always_ff @(posedge clk) begin
    glyph_row <= y[ROW_BITS-1:0];
    glyph_col <= x[COL_BITS-1:0];
  end

endmodule

/* source/scoreboard_top.sv */
module scoreboard_top import text_pkg::*, video_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       blue_inc,
  input  logic       red_inc,
  input  logic       score_clear,
  output logic       hsync,
  output logic       vsync,
  output logic       active,
  output char_code_t char_code,
  output glyph_row_t glyph_row,
  output glyph_col_t glyph_col
);

  // raster position and raw flags
  coord_t     x;
  coord_t     y;
  logic       hsync_raw;
  logic       vsync_raw;
  logic       active_raw;
  // label lookup
  label_idx_t cell_idx;
  char_code_t blue_label;
  char_code_t red_label;
  // score digits as ascii
  char_code_t blue_tens;
  char_code_t blue_ones;
  char_code_t red_tens;
  char_code_t red_ones;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_video_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .x          (x),
    .y          (y),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .active_raw (active_raw)
  );

  // one rom per player row
  label_rom #(.PLAYER(PLAYER_BLUE)) u_blue_label (
    .cell_idx  (cell_idx),
    .char_code (blue_label)
  );

  label_rom #(.PLAYER(PLAYER_RED)) u_red_label (
    .cell_idx  (cell_idx),
    .char_code (red_label)
  );

  score_digits u_score_digits (
    .clk         (clk),
    .rst_n       (rst_n),
    .blue_inc    (blue_inc),
    .red_inc     (red_inc),
    .score_clear (score_clear),
    .blue_tens   (blue_tens),
    .blue_ones   (blue_ones),
    .red_tens    (red_tens),
    .red_ones    (red_ones)
  );

  text_layer u_text_layer (
    .clk        (clk),
    .rst_n      (rst_n),
    .x          (x),
    .y          (y),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .active_raw (active_raw),
    .cell_idx   (cell_idx),
    .blue_label (blue_label),
    .red_label  (red_label),
    .blue_tens  (blue_tens),
    .blue_ones  (blue_ones),
    .red_tens   (red_tens),
    .red_ones   (red_ones),
    .hsync      (hsync),
    .vsync      (vsync),
    .active     (active),
    .char_code  (char_code),
    .glyph_row  (glyph_row),
    .glyph_col  (glyph_col)
  );

endmodule

/* testbench/tb_scoreboard.sv */
module tb_scoreboard import text_pkg::*, video_pkg::*; ();

  // small raster, 20 text columns by 3 text rows
  localparam int H_ACTIVE = 160;
  localparam int H_FRONT = 8;
  localparam int H_SYNC = 16;
  localparam int H_BACK = 8;
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT = 2;
  localparam int V_SYNC = 2;
  localparam int V_BACK = 4;
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int TEXT_COLS = H_ACTIVE / CELL_W;
  // 13 cell searches of up to two frames each, three frames of period counting
  localparam int TEST_FRAMES = 2 * 13 + 3;
  localparam int WATCHDOG_CYCLES = (TEST_FRAMES + 1) * H_TOTAL * V_TOTAL;
  // ascii space
  localparam char_code_t SPACE = 7'h20;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       blue_inc;
  logic       red_inc;
  logic       score_clear;
  logic       hsync;
  logic       vsync;
  logic       active;
  char_code_t char_code;
  glyph_row_t glyph_row;
  glyph_col_t glyph_col;
  // expected scores
  int         blue_cnt = 0;
  int         red_cnt = 0;

  always #(20) clk = ~clk;

  scoreboard_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .blue_inc    (blue_inc),
    .red_inc     (red_inc),
    .score_clear (score_clear),
    .hsync       (hsync),
    .vsync       (vsync),
    .active      (active),
    .char_code   (char_code),
    .glyph_row   (glyph_row),
    .glyph_col   (glyph_col)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_code(input string name, input char_code_t got, input char_code_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_glyph(input glyph_row_t got_row, input glyph_col_t got_col,
                             input glyph_row_t exp_row, input glyph_col_t exp_col);
    if (got_row !== exp_row) begin
      fail_run($sformatf("Error: glyph_row got 0x%h expected 0x%h", got_row, exp_row));
    end
    if (got_col !== exp_col) begin
      fail_run($sformatf("Error: glyph_col got 0x%h expected 0x%h", got_col, exp_col));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // clock counts measured on the sync and active levels
  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // idle raster, syncs high, blank and inactive
  task automatic expect_idle_outputs();
    check_bit("hsync", hsync, 1'b1);
    check_bit("vsync", vsync, 1'b1);
    check_bit("active", active, 1'b0);
    check_code("char_code", char_code, SPACE);
  endtask

  // one strobe cycle, driven just after the rising edge
  task automatic strobe_scores(input logic b, input logic r, input logic c);
    @(posedge clk);
    #2;
    blue_inc = b;
    red_inc = r;
    score_clear = c;
    @(posedge clk);
    #2;
    blue_inc = 1'b0;
    red_inc = 1'b0;
    score_clear = 1'b0;
    // clear wins over any increment
    blue_cnt = c ? 0 : (blue_cnt + b) % 100;
    red_cnt = c ? 0 : (red_cnt + r) % 100;
  endtask

  // stop on the output cycle of pixel (col*8, row*16+line_off) of the next full frame
  task automatic seek_cell(input int row, input int col, input int line_off);
    int   line;
    int   px;
    logic prev;
    line = -1;
    px = 0;
    @(negedge clk);
    while (vsync !== 1'b0) begin
      @(negedge clk);
    end
    while (vsync !== 1'b1) begin
      @(negedge clk);
    end
    prev = active;
    while (!(active === 1'b1 && line == row * CELL_H + line_off && px == col * CELL_W)) begin
      @(negedge clk);
      // rising active marks the start of a visible line
      if (active === 1'b1 && prev !== 1'b1) begin
        line++;
        px = 0;
      end else if (active === 1'b1) begin
        px++;
      end
      prev = active;
    end
  endtask

  task automatic cycles_to_fall(input logic use_vsync, output int cycles);
    logic prev;
    logic cur;
    cycles = 0;
    cur = use_vsync ? vsync : hsync;
    do begin
      prev = cur;
      @(negedge clk);
      cycles++;
      cur = use_vsync ? vsync : hsync;
    end while (!(prev === 1'b1 && cur === 1'b0));
  endtask

  task automatic raster_timing();
    int n;
    cycles_to_fall(1'b0, n);
    cycles_to_fall(1'b0, n);
    check_count("hsync period", n, H_TOTAL);
    cycles_to_fall(1'b1, n);
    cycles_to_fall(1'b1, n);
    check_count("vsync period", n, H_TOTAL * V_TOTAL);
    // active run length on every visible line
    seek_cell(0, 0, 0);
    for (int ln = 0; ln < V_ACTIVE; ln++) begin
      n = 0;
      while (active === 1'b1) begin
        n++;
        @(negedge clk);
      end
      check_count($sformatf("active length line %0d", ln), n, H_ACTIVE);
      while (ln < V_ACTIVE - 1 && active !== 1'b1) begin
        @(negedge clk);
      end
    end
  endtask

  // first pixel of each cell along one text row
  task automatic scan_row(input int row, input string exp);
    seek_cell(row, 0, 0);
    for (int c = 0; c < TEXT_COLS; c++) begin
      check_code($sformatf("char_code row %0d col %0d", row, c), char_code,
                 char_code_t'(exp[c]));
      repeat (CELL_W) @(negedge clk);
    end
  endtask

  task automatic score_rows();
    scan_row(0, {"BLUE   Player  :", $sformatf("%02d", blue_cnt), "  "});
    scan_row(1, {"RED    Player  :", $sformatf("%02d", red_cnt), "  "});
  endtask

  // mixed strobes, each player's count checked against its own total
  task automatic random_scoring();
    int nb;
    int nr;
    nb = $urandom_range(60);
    nr = $urandom_range(60);
    while (nb > 0 || nr > 0) begin
      if (nr == 0 || (nb > 0 && $urandom_range(1) == 0)) begin
        strobe_scores(1'b1, 1'b0, 1'b0);
        nb--;
      end else begin
        strobe_scores(1'b0, 1'b1, 1'b0);
        nr--;
      end
    end
    score_rows();
  endtask

  // red ones digit cell, every pixel of all 16 lines
  task automatic glyph_walk();
    string digits;
    digits = $sformatf("%02d", red_cnt);
    seek_cell(1, SCORE_COL + 1, 0);
    for (int r = 0; r < CELL_H; r++) begin
      for (int i = 0; i < CELL_W; i++) begin
        check_glyph(glyph_row, glyph_col, glyph_row_t'(r), glyph_col_t'(i));
        check_code("char_code in digit cell", char_code, char_code_t'(digits[1]));
        @(negedge clk);
      end
      while (active === 1'b1) begin
        @(negedge clk);
      end
      while (active !== 1'b1) begin
        @(negedge clk);
      end
      repeat ((SCORE_COL + 1) * CELL_W) @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(72624));
    rst_n = 1'b0;
    blue_inc = 1'b0;
    red_inc = 1'b0;
    score_clear = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #2;
      expect_idle_outputs();
    end
    rst_n = 1'b1;
    // reset values still flow through the output stage
    repeat (2) begin
      @(negedge clk);
      expect_idle_outputs();
    end
    raster_timing();
    score_rows();
    scan_row(2, {"          ", "          "});
    random_scoring();
    // full wrap leaves the blue score unchanged
    repeat (100) strobe_scores(1'b1, 1'b0, 1'b0);
    score_rows();
    strobe_scores(1'b0, 1'b1, 1'b0);
    glyph_walk();
    // clear on its own
    strobe_scores(1'b0, 1'b0, 1'b1);
    score_rows();
    // clear together with both increments
    strobe_scores(1'b1, 1'b1, 1'b0);
    strobe_scores(1'b1, 1'b1, 1'b1);
    score_rows();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("timeout, the tests did not finish in the expected number of frames");
  end

endmodule

/* list.f */
source/text_pkg.sv
source/video_pkg.sv
source/video_timing.sv
source/label_rom.sv
source/score_digits.sv
source/text_layer.sv
source/scoreboard_top.sv
testbench/tb_scoreboard.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scoreboard
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
